// File: src.f
+incdir+src
src/druaga_pkg.sv
src/rom_loader.sv
src/rom_bank.sv
src/rom_fetch_mux.sv
src/core_ctrl.sv
src/druaga_rom_top.sv
test/druaga_rom_props.sv
test/tb_druaga_rom_top.sv

// File: run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
	--top-module tb_druaga_rom_top -o tb_sim > build.log 2>&1 || { echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator exited with an error"
grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Verification passed" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

// File: test/tb_druaga_rom_top.sv
`timescale 1ns/1ps

`include "druaga_params.svh"

module tb_druaga_rom_top import druaga_pkg::*; ();

	localparam int n_pre = 20;
	localparam int n_wr = 300;
	localparam int n_out = 40;
	localparam int n_status = 8;
	// Roughly one cycle per item in every phase, doubled
	localparam int timeout_cycles = 2 * (8 + n_pre + 3 * n_wr + n_out + 6 * n_status + 200);
	localparam int base_of [4] = '{int'(`DRUAGA_CPU0_BASE), int'(`DRUAGA_SPRITE_BASE),
		int'(`DRUAGA_CPU1_BASE), int'(`DRUAGA_BG_BASE)};
	localparam int depth_of [4] = '{`DRUAGA_CPU0_DEPTH, `DRUAGA_SPRITE_DEPTH,
		`DRUAGA_CPU1_DEPTH, `DRUAGA_BG_DEPTH};

	logic                        clock_48;
	logic                        rst_n;
	logic                        ioctl_download;
	logic                        ioctl_wr;
	logic [24:0]                 ioctl_addr;
	logic [7:0]                  ioctl_dout;
	logic                        fetch_req;
	region_t                     fetch_region;
	logic [`DRUAGA_LOCAL_AW-1:0] fetch_addr;
	logic [`DRUAGA_STATUS_W-1:0] status;
	logic                        reset_button;
	model_t                      model;
	logic                        fetch_valid;
	logic [7:0]                  fetch_data;
	logic                        game_reset;
	logic [7:0]                  dsw0;
	logic [7:0]                  dsw1;
	logic [7:0]                  dsw2;

	// Reference model state
	logic [7:0]  m_mem [4][32768];
	logic        m_loaded;
	logic        m_dl_d;
	logic        exp_reset;
	logic [7:0]  exp_dsw0;
	logic [7:0]  exp_dsw1;
	logic [7:0]  exp_dsw2;
	logic        pipe_valid;
	logic [7:0]  pipe_data;
	logic        exp_valid;
	logic [7:0]  exp_data;
	int          issued;
	int          seen;
	int          cycles;
	logic [15:0] lfsr = 16'd9827;
	region_t     wr_region [$];
	logic [14:0] wr_local [$];

	druaga_rom_top i_dut (.*);

	initial clock_48 = 1'b0;
	always #2 clock_48 = ~clock_48;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [7:0] expected_dsw2(input model_t md, input logic [31:0] s);
		case (md)
			druaga, druaga_alt, digdug2: return {s[19:16], s[27:24]};
			mappy: return {s[27:24], s[27:24]};
			default: return s[31:24];
		endcase
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Verification failed");
			$fatal(1, "Stopped at first error");
		end
	endtask

	// Back-to-back fetches of every written byte, then drain
	task automatic fetch_written();
		logic [31:0] r;
		foreach (wr_local[i]) begin
			@(negedge clock_48);
			r = rand_bits(3);
			fetch_req = 1'b1;
			fetch_region = wr_region[i];
			// Multiples of the depth land on the same byte
			fetch_addr = 15'(int'(wr_local[i]) + int'(r[2:0]) * depth_of[wr_region[i]]);
		end
		@(negedge clock_48);
		fetch_req = 1'b0;
		while (seen != issued)
			@(negedge clock_48);
	endtask

	always @(posedge clock_48) begin
		int          ia;
		logic [2:0]  k;
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: run still going after %0d cycles", cycles);
			$display("Verification failed");
			$fatal(1, "Run hung");
		end
		if (!rst_n) begin
			m_loaded = 1'b0;
			m_dl_d = 1'b0;
			exp_reset = 1'b1;
			exp_dsw0 = '0;
			exp_dsw1 = '0;
			exp_dsw2 = '0;
			pipe_valid = 1'b0;
			exp_valid = 1'b0;
		end else begin
			// Fetch reads the array before this edge's write lands
			exp_valid = pipe_valid;
			exp_data = pipe_data;
			pipe_valid = fetch_req && !exp_reset;
			if (pipe_valid) begin
				issued++;
				pipe_data = m_mem[fetch_region][15'(int'(fetch_addr) % depth_of[fetch_region])];
			end
			ia = int'(ioctl_addr);
			for (k = 3'd0; k < 3'd4; k++)
				if (ioctl_wr && ia >= base_of[k[1:0]] &&
					ia < base_of[k[1:0]] + depth_of[k[1:0]])
					m_mem[k[1:0]][15'(ia - base_of[k[1:0]])] = ioctl_dout;
			exp_reset = status[0] | reset_button | ioctl_download | !m_loaded;
			if (m_dl_d && !ioctl_download)
				m_loaded = 1'b1;
			m_dl_d = ioctl_download;
			exp_dsw0 = status[15:8];
			exp_dsw1 = status[23:16];
			exp_dsw2 = expected_dsw2(model, status);
		end
	end

	always @(negedge clock_48) begin
		expect_equal("game_reset", 32'(game_reset), 32'(exp_reset));
		expect_equal("fetch_valid", 32'(fetch_valid), 32'(exp_valid));
		if (exp_valid)
			expect_equal("fetch_data", 32'(fetch_data), 32'(exp_data));
		if (fetch_valid)
			seen++;
		expect_equal("dsw0", 32'(dsw0), 32'(exp_dsw0));
		expect_equal("dsw1", 32'(dsw1), 32'(exp_dsw1));
		expect_equal("dsw2", 32'(dsw2), 32'(exp_dsw2));
	end

	initial begin
		logic [31:0] r;
		region_t     rg;
		int          idx;
		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		fetch_req = 1'b0;
		fetch_region = cpu0;
		fetch_addr = '0;
		status = '0;
		reset_button = 1'b0;
		model = druaga;
		repeat (8) @(negedge clock_48);
		rst_n = 1'b1;
		// Nothing is loaded yet, so every fetch is dropped
		repeat (n_pre) begin
			@(negedge clock_48);
			r = rand_bits(17);
			fetch_req = r[16];
			fetch_region = region_t'(r[1:0]);
			fetch_addr = r[14:0];
		end
		@(negedge clock_48);
		fetch_req = 1'b0;
		@(negedge clock_48);
		expect_equal("fetch_valid pulses", 32'(seen), 32'd0);
		ioctl_download = 1'b1;
		repeat (n_wr) begin
			@(negedge clock_48);
			r = rand_bits(25);
			rg = region_t'(r[24:23]);
			wr_region.push_back(rg);
			wr_local.push_back(15'(int'(r[14:0]) % depth_of[rg]));
			ioctl_wr = 1'b1;
			ioctl_addr = 25'(base_of[rg] + int'(wr_local[$]));
			ioctl_dout = r[22:15];
		end
		@(negedge clock_48);
		ioctl_wr = 1'b0;
		ioctl_download = 1'b0;
		while (game_reset)
			@(negedge clock_48);
		fetch_written();
		// Second download hits only the small ROMs above the map
		ioctl_download = 1'b1;
		repeat (n_out) begin
			@(negedge clock_48);
			r = rand_bits(16);
			idx = int'(r[15:7]) % wr_local.size();
			ioctl_wr = 1'b1;
			// Low bits alias a written byte, upper bits lie above the map
			ioctl_addr = 25'(base_of[wr_region[idx]] + int'(wr_local[idx]) +
				(int'(r[6:0]) + 1) * 'h20000);
			ioctl_dout = ~m_mem[wr_region[idx]][wr_local[idx]];
		end
		@(negedge clock_48);
		ioctl_wr = 1'b0;
		ioctl_download = 1'b0;
		while (game_reset)
			@(negedge clock_48);
		fetch_written();
		status = 32'h1;
		while (!game_reset)
			@(negedge clock_48);
		status = '0;
		while (game_reset)
			@(negedge clock_48);
		reset_button = 1'b1;
		while (!game_reset)
			@(negedge clock_48);
		reset_button = 1'b0;
		while (game_reset)
			@(negedge clock_48);
		// Model code 5 is one of the reserved ones
		for (int m = 0; m < 6; m++) begin
			repeat (n_status) begin
				@(negedge clock_48);
				model = model_t'(3'(m));
				status = rand_bits(32);
			end
		end
		repeat (2) @(negedge clock_48);
		if (seen == issued && seen > 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Fetch count wrong: %0d accepted, %0d returned", issued, seen);
			$display("Verification failed");
			$fatal(1, "Fetch count check");
		end
	end

endmodule

// File: test/druaga_rom_props.sv
`timescale 1ns/1ps

module druaga_rom_props (
	input logic clock_48,
	input logic rst_n,
	input logic ioctl_download,
	input logic fetch_req,
	input logic game_reset,
	input logic fetch_valid
);

	logic accepted;

	assign accepted = fetch_req && !game_reset;

	// Bank read plus mux register
	a_valid_after_fetch: assert property (
		@(posedge clock_48) disable iff (!rst_n)
		$past(accepted, 2) |-> fetch_valid
	) else $error("fetch_valid missing two cycles after an accepted fetch");

	a_no_stray_valid: assert property (
		@(posedge clock_48) disable iff (!rst_n)
		fetch_valid |-> $past(accepted, 2)
	) else $error("fetch_valid without an accepted fetch two cycles earlier");

	a_reset_in_download: assert property (
		@(posedge clock_48) disable iff (!rst_n)
		$past(ioctl_download) |-> game_reset
	) else $error("game_reset low in the cycle after a download cycle");

endmodule

bind druaga_rom_top druaga_rom_props i_props (
	.clock_48       (clock_48),
	.rst_n          (rst_n),
	.ioctl_download (ioctl_download),
	.fetch_req      (fetch_req),
	.game_reset     (game_reset),
	.fetch_valid    (fetch_valid)
);

// File: src/druaga_rom_top.sv
`timescale 1ns/1ps

`include "druaga_params.svh"

module druaga_rom_top import druaga_pkg::*; (
	input  logic                        clock_48,
	input  logic                        rst_n,
	input  logic                        ioctl_download,
	input  logic                        ioctl_wr,
	input  logic [24:0]                 ioctl_addr,
	input  logic [7:0]                  ioctl_dout,
	input  logic                        fetch_req,
	input  region_t                     fetch_region,
	input  logic [`DRUAGA_LOCAL_AW-1:0] fetch_addr,
	input  logic [`DRUAGA_STATUS_W-1:0] status,
	input  logic                        reset_button,
	input  model_t                      model,
	output logic                        fetch_valid,
	output logic [7:0]                  fetch_data,
	output logic                        game_reset,
	output logic [7:0]                  dsw0,
	output logic [7:0]                  dsw1,
	output logic [7:0]                  dsw2
);

	logic [`DRUAGA_BANKS-1:0]      bank_we;
	logic [`DRUAGA_LOCAL_AW-1:0]   bank_waddr;
	logic [7:0]                    bank_wdata;
	logic [`DRUAGA_BANKS-1:0]      bank_re;
	logic [`DRUAGA_LOCAL_AW-1:0]   bank_raddr;
	logic [`DRUAGA_BANKS-1:0][7:0] bank_rdata;

	rom_loader i_loader (
		.clock_48   (clock_48),
		.rst_n      (rst_n),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.bank_we    (bank_we),
		.bank_waddr (bank_waddr),
		.bank_wdata (bank_wdata)
	);

	// Bank order follows region_t
	for (genvar i = 0; i < `DRUAGA_BANKS; i++) begin : g_bank
		localparam int depth = (i == 0) ? `DRUAGA_CPU0_DEPTH :
		                       (i == 1) ? `DRUAGA_SPRITE_DEPTH :
		                       (i == 2) ? `DRUAGA_CPU1_DEPTH : `DRUAGA_BG_DEPTH;

		rom_bank #(
			.depth  (depth),
			.addr_w (`DRUAGA_LOCAL_AW)
		) i_bank (
			.clock_48 (clock_48),
			.we       (bank_we[i]),
			.waddr    (bank_waddr),
			.wdata    (bank_wdata),
			.re       (bank_re[i]),
			.raddr    (bank_raddr),
			.rdata    (bank_rdata[i])
		);
	end

	rom_fetch_mux i_fetch (
		.clock_48     (clock_48),
		.rst_n        (rst_n),
		.game_reset   (game_reset),
		.fetch_req    (fetch_req),
		.fetch_region (fetch_region),
		.fetch_addr   (fetch_addr),
		.bank_rdata   (bank_rdata),
		.bank_re      (bank_re),
		.bank_raddr   (bank_raddr),
		.fetch_valid  (fetch_valid),
		.fetch_data   (fetch_data)
	);

	core_ctrl i_ctrl (
		.clock_48       (clock_48),
		.rst_n          (rst_n),
		.status         (status),
		.reset_button   (reset_button),
		.model          (model),
		.ioctl_download (ioctl_download),
		.game_reset     (game_reset),
		.dsw0           (dsw0),
		.dsw1           (dsw1),
		.dsw2           (dsw2)
	);

endmodule

// File: src/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl import druaga_pkg::*; (
	input  logic        clock_48,
	input  logic        rst_n,
	input  logic [31:0] status,
	input  logic        reset_button,
	input  model_t      model,
	input  logic        ioctl_download,
	output logic        game_reset,
	output logic [7:0]  dsw0,
	output logic [7:0]  dsw1,
	output logic [7:0]  dsw2
);

	logic       download_d;
	logic       rom_loaded;
	logic [7:0] dsw2_next;

	// Loaded once the first download has ended
	always_ff @(posedge clock_48 or negedge rst_n) begin
		if (!rst_n) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			download_d <= ioctl_download;
			if (download_d && !ioctl_download)
				rom_loaded <= 1'b1;
		end
	end

	always_ff @(posedge clock_48 or negedge rst_n) begin
		if (!rst_n)
			game_reset <= 1'b1;
		else
			game_reset <= status[0] | reset_button | ioctl_download | ~rom_loaded;
	end

	// Per-model layout of the third DIP bank
	always_comb begin
		case (model)
			druaga, druaga_alt, digdug2: begin
				dsw2_next = {status[19:16], status[27:24]};
			end
			mappy: begin
				dsw2_next = {2{status[27:24]}};
			end
			default: begin
				// Motos and unused model codes
				dsw2_next = status[31:24];
			end
		endcase
	end

	always_ff @(posedge clock_48 or negedge rst_n) begin
		if (!rst_n) begin
			dsw0 <= '0;
			dsw1 <= '0;
			dsw2 <= '0;
		end else begin
			dsw0 <= status[15:8];
			dsw1 <= status[23:16];
			dsw2 <= dsw2_next;
		end
	end

endmodule

// File: src/rom_fetch_mux.sv
`timescale 1ns/1ps

`include "druaga_params.svh"

module rom_fetch_mux import druaga_pkg::*; (
	input  logic                              clock_48,
	input  logic                              rst_n,
	input  logic                              game_reset,
	input  logic                              fetch_req,
	input  region_t                           fetch_region,
	input  logic [`DRUAGA_LOCAL_AW-1:0]       fetch_addr,
	input  logic [`DRUAGA_BANKS-1:0][7:0]     bank_rdata,
	output logic [`DRUAGA_BANKS-1:0]          bank_re,
	output logic [`DRUAGA_LOCAL_AW-1:0]       bank_raddr,
	output logic                              fetch_valid,
	output logic [7:0]                        fetch_data
);

	logic    accept;
	logic    accept_q;
	region_t region_q;

	// Fetches during game reset are dropped
	assign accept = fetch_req && !game_reset;

	always_comb begin
		bank_re = '0;
		if (accept)
			bank_re[fetch_region] = 1'b1;
	end

	assign bank_raddr = fetch_addr;

	always_ff @(posedge clock_48 or negedge rst_n) begin
		if (!rst_n) begin
			accept_q <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			accept_q <= accept;
			fetch_valid <= accept_q;
		end
	end

	// Bank byte is ready one edge after the strobe
	always_ff @(posedge clock_48) begin
		region_q <= fetch_region;
		if (accept_q)
			fetch_data <= bank_rdata[region_q];
	end

endmodule

// File: src/rom_bank.sv
`timescale 1ns/1ps

module rom_bank #(
	parameter int depth  = 4096,
	parameter int addr_w = 15
) (
	input  logic              clock_48,
	input  logic              we,
	input  logic [addr_w-1:0] waddr,
	input  logic [7:0]        wdata,
	input  logic              re,
	input  logic [addr_w-1:0] raddr,
	output logic [7:0]        rdata
);

	// Depths are powers of two, so modulo is a bit slice
	localparam int aw = $clog2(depth);

	logic [7:0]    mem [depth];
	logic [aw-1:0] wa;
	logic [aw-1:0] ra;
	logic          bypass;

	assign wa = waddr[aw-1:0];
	assign ra = raddr[aw-1:0];

	// A read on the write edge sees the byte being written
	assign bypass = we && (wa == ra);

	always_ff @(posedge clock_48) begin
		if (we)
			mem[wa] <= wdata;
	end

	always_ff @(posedge clock_48) begin
		if (re) begin
			if (bypass)
				rdata <= wdata;
			else
				rdata <= mem[ra];
		end
	end

endmodule

// File: src/rom_loader.sv
`timescale 1ns/1ps

`include "druaga_params.svh"

module rom_loader import druaga_pkg::*; (
	input  logic                        clock_48,
	input  logic                        rst_n,
	input  logic                        ioctl_wr,
	input  logic [24:0]                 ioctl_addr,
	input  logic [7:0]                  ioctl_dout,
	output logic [`DRUAGA_BANKS-1:0]    bank_we,
	output logic [`DRUAGA_LOCAL_AW-1:0] bank_waddr,
	output logic [7:0]                  bank_wdata
);

	region_t     region;
	logic        hit;
	logic [24:0] offset;
	logic [24:0] off_cpu0;
	logic [24:0] off_sprite;
	logic [24:0] off_cpu1;
	logic [24:0] off_bg;

	// Unsigned wrap turns each range test into one compare
	assign off_cpu0   = ioctl_addr - `DRUAGA_CPU0_BASE;
	assign off_sprite = ioctl_addr - `DRUAGA_SPRITE_BASE;
	assign off_cpu1   = ioctl_addr - `DRUAGA_CPU1_BASE;
	assign off_bg     = ioctl_addr - `DRUAGA_BG_BASE;

	always_comb begin
		hit = 1'b1;
		region = cpu0;
		offset = off_cpu0;
		if (off_cpu0 < 25'(`DRUAGA_CPU0_DEPTH)) begin
			region = cpu0;
			offset = off_cpu0;
		end else if (off_sprite < 25'(`DRUAGA_SPRITE_DEPTH)) begin
			region = sprite;
			offset = off_sprite;
		end else if (off_cpu1 < 25'(`DRUAGA_CPU1_DEPTH)) begin
			region = cpu1;
			offset = off_cpu1;
		end else if (off_bg < 25'(`DRUAGA_BG_DEPTH)) begin
			region = bg;
			offset = off_bg;
		end else begin
			// Palette, CLUT and wave ROMs land here
			hit = 1'b0;
		end
	end

	always_ff @(posedge clock_48 or negedge rst_n) begin
		if (!rst_n) begin
			bank_we <= '0;
		end else begin
			bank_we <= '0;
			if (ioctl_wr && hit)
				bank_we[region] <= 1'b1;
		end
	end

	always_ff @(posedge clock_48) begin
		bank_waddr <= offset[`DRUAGA_LOCAL_AW-1:0];
		bank_wdata <= ioctl_dout;
	end

endmodule

// File: src/druaga_pkg.sv
package druaga_pkg;

	// Game model as selected by the menu core_mod field
	typedef enum logic [2:0] {
		druaga     = 3'd0,
		druaga_alt = 3'd1,
		mappy      = 3'd2,
		digdug2    = 3'd3,
		motos      = 3'd4
	} model_t;

	// ROM regions, also the bank index
	typedef enum logic [1:0] {
		cpu0   = 2'd0,
		sprite = 2'd1,
		cpu1   = 2'd2,
		bg     = 2'd3
	} region_t;

endpackage

// File: src/druaga_params.svh
`ifndef DRUAGA_PARAMS_SVH
`define DRUAGA_PARAMS_SVH

// ROM map of the download stream, bases in download byte addresses
`define DRUAGA_CPU0_BASE    25'h0000000
`define DRUAGA_CPU0_DEPTH   32768

`define DRUAGA_SPRITE_BASE  25'h0008000
`define DRUAGA_SPRITE_DEPTH 32768

`define DRUAGA_CPU1_BASE    25'h0010000
`define DRUAGA_CPU1_DEPTH   8192

`define DRUAGA_BG_BASE      25'h0012000
`define DRUAGA_BG_DEPTH     4096

`define DRUAGA_BANKS        4
`define DRUAGA_LOCAL_AW     15
`define DRUAGA_STATUS_W     32

`endif
